// File: design/config_chain.sv
`default_nettype none

module config_chain (
   input  logic                KLK,
   input  logic                rst_n,
   input  logic                cfg_shift,
   input  logic                cfg_bit,
   input  logic                cfg_commit,
   output lca_pkg::clb_cfg_t   cfg0,
   output lca_pkg::clb_cfg_t   cfg1,
   output lca_pkg::route_cfg_t rcfg
);

   import lca_pkg::*;

   tile_img_t shift_q;
   tile_img_t active_q;

   // the first bit shifted in ends up in the msb.
   always_ff @(posedge KLK)
   begin
      if (cfg_shift)
      begin
         shift_q <= {shift_q[TILE_CFG_BITS-2:0], cfg_bit};
      end
   end

   // active image only changes on commit.
   always_ff @(posedge KLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         active_q <= '0;
      end
      else if (cfg_commit)
      begin
         active_q <= shift_q;
      end
   end

   // slice the committed image.
   assign cfg0 = clb_cfg_t'(active_q[TILE_CFG_BITS-1 -: CLB_CFG_BITS]);
   assign cfg1 = clb_cfg_t'(active_q[ROUTE_CFG_BITS +: CLB_CFG_BITS]);
   assign rcfg = route_cfg_t'(active_q[ROUTE_CFG_BITS-1:0]);

endmodule

`default_nettype wire

// File: design/lca_pkg.sv
`default_nettype none

package lca_pkg;

   localparam int LUT_BITS       = 16;
   localparam int LUT_ADDR_BITS  = 4;
   localparam int CLB_CFG_BITS   = 37;
   localparam int ROUTE_CFG_BITS = 4;
   // image order is block0, block1, route, most significant first.
   localparam int TILE_CFG_BITS  = 2 * CLB_CFG_BITS + ROUTE_CFG_BITS;

   typedef logic [LUT_BITS-1:0]      lut_t;
   typedef logic [LUT_ADDR_BITS-1:0] lut_addr_t;
   typedef logic [1:0]               comb_mode_t;
   typedef logic [1:0]               sel2_t;
   typedef logic [1:0]               route_sel_t;
   typedef logic [TILE_CFG_BITS-1:0] tile_img_t;

   // combine mode code 3 acts like COMB_BSEL.
   localparam comb_mode_t COMB_4IN  = 2'd0;
   localparam comb_mode_t COMB_2X3  = 2'd1;
   localparam comb_mode_t COMB_BSEL = 2'd2;

   typedef struct packed {
      lut_t       lut;
      comb_mode_t comb_mode;
      logic [2:0] f_pin_sel;
      logic [2:0] g_pin_sel;
      logic [1:0] dq_sel;
      sel2_t      set_sel;
      sel2_t      clk_sel;
      sel2_t      rst_sel;
      sel2_t      x_sel;
      sel2_t      y_sel;
      logic       latch_mode;
   } clb_cfg_t;

   typedef struct packed {
      route_sel_t out0_sel;
      route_sel_t out1_sel;
   } route_cfg_t;

   typedef struct packed {
      logic a;
      logic b;
      logic c;
      logic d;
      logic k;
   } blk_pins_t;

   typedef struct packed {
      logic x;
      logic y;
   } blk_out_t;

endpackage

`default_nettype wire

// File: design/logic_block.sv
`default_nettype none

module logic_block (
   input  logic              KLK,
   input  logic              rst_n,
   input  lca_pkg::clb_cfg_t cfg,
   input  lca_pkg::blk_pins_t pins,
   output lca_pkg::blk_out_t outs
);

   import lca_pkg::*;

   lut_addr_t f_addr;
   lut_addr_t g_addr;
   logic      dq1;
   logic      dq2;
   logic      f_a;
   logic      f_b;
   logic      f_c;
   logic      g_a;
   logic      g_b;
   logic      g_c;
   logic      f;
   logic      g;
   logic      set_s;
   logic      rst_s;
   logic      clk_src;
   logic      clk_prev;
   logic      load;
   logic      q;

   // codes 2 and 3 of a three-way pick both give in2.
   function automatic logic pick3(
      input sel2_t sel,
      input logic  in0,
      input logic  in1,
      input logic  in2
   );
      logic r;
      case (sel)
         2'd0:    r = in0;
         2'd1:    r = in1;
         default: r = in2;
      endcase
      return r;
   endfunction

   assign dq1 = cfg.dq_sel[0] ? q : pins.d;
   assign dq2 = cfg.dq_sel[1] ? q : pins.d;

   // split mode swaps a/b with bit 0, b/c with bit 1 and c/dq with bit 2.
   assign f_a = cfg.f_pin_sel[0] ? pins.b : pins.a;
   assign f_b = cfg.f_pin_sel[1] ? pins.c : pins.b;
   assign f_c = cfg.f_pin_sel[2] ? dq1    : pins.c;
   assign g_a = cfg.g_pin_sel[0] ? pins.b : pins.a;
   assign g_b = cfg.g_pin_sel[1] ? pins.c : pins.b;
   assign g_c = cfg.g_pin_sel[2] ? dq2    : pins.c;

   always_comb
   begin
      case (cfg.comb_mode)
         COMB_4IN:
         begin
            f_addr = {pins.a, pins.b, pins.c, dq1};
            g_addr = f_addr;
         end
         COMB_2X3:
         begin
            f_addr = {1'b0, f_a, f_b, f_c};
            g_addr = {1'b1, g_a, g_b, g_c};
         end
         default:
         begin
            // b picks the table half.
            if (pins.b)
            begin
               f_addr = {1'b1, pins.a, pins.c, dq2};
            end
            else
            begin
               f_addr = {1'b0, pins.a, pins.c, dq1};
            end
            g_addr = f_addr;
         end
      endcase
   end

   assign f = cfg.lut[f_addr];
   assign g = cfg.lut[g_addr];

   assign set_s   = pick3(cfg.set_sel, pins.a, f, 1'b0);
   assign clk_src = pick3(cfg.clk_sel, g, pins.c, pins.k);
   assign rst_s   = pick3(cfg.rst_sel, pins.d, g, 1'b0);

   // flop loads on a rising source, latch on a high source.
   assign load = cfg.latch_mode ? clk_src : (clk_src & ~clk_prev);

   always_ff @(posedge KLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         clk_prev <= 1'b0;
         q        <= 1'b0;
      end
      else
      begin
         clk_prev <= clk_src;
         if (load)
         begin
            // reset wins over set.
            if (rst_s)
            begin
               q <= 1'b0;
            end
            else if (set_s)
            begin
               q <= 1'b1;
            end
            else
            begin
               q <= f;
            end
         end
      end
   end

   assign outs.x = pick3(cfg.x_sel, f, g, q);
   assign outs.y = pick3(cfg.y_sel, q, g, f);

endmodule

`default_nettype wire

// File: design/logic_tile.sv
`default_nettype none

module logic_tile (
   input  logic               KLK,
   input  logic               rst_n,
   input  logic               cfg_shift,
   input  logic               cfg_bit,
   input  logic               cfg_commit,
   input  lca_pkg::blk_pins_t pins0,
   input  lca_pkg::blk_pins_t pins1,
   output logic [1:0]         tile_out
);

   import lca_pkg::*;

   clb_cfg_t   cfg0;
   clb_cfg_t   cfg1;
   route_cfg_t rcfg;
   blk_out_t   blk0_out;
   blk_out_t   blk1_out;

   config_chain config_chain_i (
      .KLK        (KLK),
      .rst_n      (rst_n),
      .cfg_shift  (cfg_shift),
      .cfg_bit    (cfg_bit),
      .cfg_commit (cfg_commit),
      .cfg0       (cfg0),
      .cfg1       (cfg1),
      .rcfg       (rcfg)
   );

   logic_block blk0_i (
      .KLK   (KLK),
      .rst_n (rst_n),
      .cfg   (cfg0),
      .pins  (pins0),
      .outs  (blk0_out)
   );

   logic_block blk1_i (
      .KLK   (KLK),
      .rst_n (rst_n),
      .cfg   (cfg1),
      .pins  (pins1),
      .outs  (blk1_out)
   );

   output_router output_router_i (
      .rcfg     (rcfg),
      .blk0     (blk0_out),
      .blk1     (blk1_out),
      .tile_out (tile_out)
   );

endmodule

`default_nettype wire

// File: design/output_router.sv
`default_nettype none

module output_router (
   input  lca_pkg::route_cfg_t rcfg,
   input  lca_pkg::blk_out_t   blk0,
   input  lca_pkg::blk_out_t   blk1,
   output logic [1:0]          tile_out
);

   import lca_pkg::*;

   // 4-to-1 over the block outputs.
   function automatic logic pick4(
      input route_sel_t sel,
      input blk_out_t   b0,
      input blk_out_t   b1
   );
      logic r;
      case (sel)
         2'd0:    r = b0.x;
         2'd1:    r = b0.y;
         2'd2:    r = b1.x;
         default: r = b1.y;
      endcase
      return r;
   endfunction

   always_comb
   begin
      tile_out[0] = pick4(rcfg.out0_sel, blk0, blk1);
      tile_out[1] = pick4(rcfg.out1_sel, blk0, blk1);
   end

endmodule

`default_nettype wire

// File: filelist.f
design/lca_pkg.sv
design/config_chain.sv
design/logic_block.sv
design/output_router.sv
design/logic_tile.sv
tb/logic_tile_checker.sv
tb/logic_tile_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
   -f filelist.f --top-module logic_tile_tb -o logic_tile_sim
./obj_dir/logic_tile_sim | tee sim.log
if grep -q "^TEST OK$" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// File: tb/logic_tile_checker.sv
`default_nettype none

module logic_tile_checker (
   input logic              KLK,
   input logic              rst_n,
   input logic              load,
   input logic              rst_s,
   input logic              q,
   input lca_pkg::clb_cfg_t cfg,
   input lca_pkg::blk_out_t outs
);

   timeunit 1ns;
   timeprecision 100ps;

   // storage only moves on a load.
   q_holds: assert property (@(posedge KLK) disable iff (!rst_n) !load |=> $stable(q))
      else $error("q changed in a cycle without a load");

   q_reset_wins: assert property (@(posedge KLK) disable iff (!rst_n) (load && rst_s) |=> !q)
      else $error("reset did not clear q on a load");

   // zero image after reset gives low outputs.
   zero_after_reset: assert property (@(posedge KLK) disable iff (!rst_n)
      ($rose(rst_n) && cfg == '0) |=> outs == '0)
      else $error("block outputs not low after reset with the zero configuration");

endmodule

bind logic_block logic_tile_checker logic_tile_checker_i (
   .KLK   (KLK),
   .rst_n (rst_n),
   .load  (load),
   .rst_s (rst_s),
   .q     (q),
   .cfg   (cfg),
   .outs  (outs)
);

`default_nettype wire

// File: tb/logic_tile_tb.sv
`default_nettype none

module logic_tile_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import lca_pkg::*;

   localparam int CLK_PERIOD = 40;

   typedef struct packed {
      tile_img_t  img;
      blk_pins_t  p0;
      blk_pins_t  p1;
      logic       load_cfg;
      logic       rnd;
      logic [1:0] exp;
   } row_t;

   logic       KLK;
   logic       rst_n;
   logic       cfg_shift;
   logic       cfg_bit;
   logic       cfg_commit;
   blk_pins_t  pins0;
   blk_pins_t  pins1;
   logic [1:0] tile_out;

   row_t      rows[$];
   tile_img_t model_img;
   tile_img_t next_img;
   logic      mq[2];
   logic      mprev[2];
   integer    seed = 32'h4eef6f5c;
   int        errors = 0;
   int        checks = 0;
   bit        table_ready = 0;

   logic_tile logic_tile_i (.*);

   initial
   begin
      KLK = 1'b0;
      forever #(CLK_PERIOD/2) KLK = ~KLK;
   end

   function automatic logic choose3(input sel2_t s, input logic in0, in1, in2);
      if (s == 2'd0)
         return in0;
      if (s == 2'd1)
         return in1;
      return in2;
   endfunction

   // reference lut read that returns {f, g}.
   function automatic logic [1:0] lut_fg(input clb_cfg_t c, input blk_pins_t p, input logic qv);
      logic       dq1;
      logic       dq2;
      logic [3:0] fi;
      logic [3:0] gi;
      dq1 = c.dq_sel[0] ? qv : p.d;
      dq2 = c.dq_sel[1] ? qv : p.d;
      fi = p.b ? {1'b1, p.a, p.c, dq2} : {1'b0, p.a, p.c, dq1};
      gi = fi;
      if (c.comb_mode == 2'd0)
      begin
         fi = {p.a, p.b, p.c, dq1};
         gi = fi;
      end
      else if (c.comb_mode == 2'd1)
      begin
         fi = {1'b0, c.f_pin_sel[0] ? p.b : p.a, c.f_pin_sel[1] ? p.c : p.b,
               c.f_pin_sel[2] ? dq1 : p.c};
         gi = {1'b1, c.g_pin_sel[0] ? p.b : p.a, c.g_pin_sel[1] ? p.c : p.b,
               c.g_pin_sel[2] ? dq2 : p.c};
      end
      return {c.lut[fi], c.lut[gi]};
   endfunction

   function automatic logic [1:0] model_out();
      clb_cfg_t   c0;
      clb_cfg_t   c1;
      route_cfg_t r;
      logic [1:0] fg0;
      logic [1:0] fg1;
      logic [3:0] src;
      {c0, c1, r} = model_img;
      fg0 = lut_fg(c0, pins0, mq[0]);
      fg1 = lut_fg(c1, pins1, mq[1]);
      // router sources in select order.
      src[0] = choose3(c0.x_sel, fg0[1], fg0[0], mq[0]);
      src[1] = choose3(c0.y_sel, mq[0], fg0[0], fg0[1]);
      src[2] = choose3(c1.x_sel, fg1[1], fg1[0], mq[1]);
      src[3] = choose3(c1.y_sel, mq[1], fg1[0], fg1[1]);
      return {src[r.out1_sel], src[r.out0_sel]};
   endfunction

   // one KLK edge of the model storage.
   task automatic advance_model();
      clb_cfg_t   c0;
      clb_cfg_t   c1;
      clb_cfg_t   cn;
      route_cfg_t r;
      blk_pins_t  pn;
      logic [1:0] fg;
      logic       src;
      logic       ld;
      int         n;
      {c0, c1, r} = model_img;
      for (n = 0; n < 2; n++)
      begin
         cn = (n == 0) ? c0 : c1;
         pn = (n == 0) ? pins0 : pins1;
         fg = lut_fg(cn, pn, mq[n]);
         src = choose3(cn.clk_sel, fg[0], pn.c, pn.k);
         ld = cn.latch_mode ? src : (src && !mprev[n]);
         mprev[n] = src;
         if (ld)
         begin
            if (choose3(cn.rst_sel, pn.d, fg[0], 1'b0))
               mq[n] = 1'b0;
            else if (choose3(cn.set_sel, pn.a, fg[1], 1'b0))
               mq[n] = 1'b1;
            else
               mq[n] = fg[1];
         end
      end
   endtask

   task automatic check_value(input string name, input logic [1:0] got, input logic [1:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Fail at %0d ns: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   // checks in the middle of the low phase that follows a falling edge.
   task automatic run_cycle(input logic [1:0] exp);
      #(CLK_PERIOD/4);
      check_value("tile_out", tile_out, exp);
      advance_model();
      if (cfg_commit)
         model_img = next_img;
      @(negedge KLK);
   endtask

   task automatic add_row(input tile_img_t img, input logic [9:0] pp, input logic ld, rnd);
      rows.push_back(row_t'({img, pp, ld, rnd, 2'b00}));
   endtask

   function automatic clb_cfg_t base_cfg(input lut_t lut);
      clb_cfg_t c;
      c = '0;
      c.lut = lut;
      c.set_sel = 2'd2;
      c.rst_sel = 2'd2;
      c.clk_sel = 2'd2;
      return c;
   endfunction

   task automatic build_table();
      clb_cfg_t   c0;
      clb_cfg_t   c1;
      route_cfg_t r;
      int         sel;
      int         v;
      logic [4:0] seq [12] = '{5'b00000, 5'b10001, 5'b00000, 5'b10011, 5'b10001, 5'b00001,
                                5'b01100, 5'b01101, 5'b01110, 5'b01111, 5'b00000, 5'b00001};
      add_row('0, {5'b10111, 5'b01101}, 1'b0, 1'b0);
      add_row('0, 10'd0, 1'b0, 1'b1);
      c0 = base_cfg(16'h6996);
      c0.y_sel = 2'd1;
      c1 = base_cfg(16'hff00);
      r = 4'b0010;
      add_row({c0, c1, r}, 10'd0, 1'b1, 1'b1);
      repeat (3) add_row({c0, c1, r}, 10'd0, 1'b0, 1'b1);
      // full address sweep where block1 holds the inverted table.
      c0 = base_cfg(16'hb4e1);
      c0.y_sel = 2'd2;
      c1 = c0;
      c1.lut = ~c0.lut;
      for (sel = 0; sel < 4; sel++)
      begin
         r = {sel[1:0], ~sel[1:0]};
         for (v = 0; v < 16; v++)
            add_row({c0, c1, r}, {v[3:0], 1'b0, v[3:0], 1'b0}, v == 0, 1'b0);
      end
      c0 = base_cfg(16'h3ac5);
      c0.comb_mode = 2'd1;
      c0.f_pin_sel = 3'b101;
      c0.g_pin_sel = 3'b010;
      c0.y_sel = 2'd1;
      c1 = '0;
      r = 4'b0001;
      add_row({c0, c1, r}, 10'd0, 1'b1, 1'b1);
      repeat (11) add_row({c0, c1, r}, 10'd0, 1'b0, 1'b1);
      c0 = base_cfg(16'h5c3a);
      c0.comb_mode = 2'd2;
      c0.dq_sel = 2'b10;
      add_row({c0, c1, r}, 10'd0, 1'b1, 1'b1);
      repeat (15) add_row({c0, c1, r}, 10'd0, 1'b0, 1'b1);
      // flop on k, set from a, reset from d.
      c0 = base_cfg(16'h00c0);
      c0.set_sel = 2'd0;
      c0.rst_sel = 2'd0;
      c0.x_sel = 2'd2;
      c0.y_sel = 2'd2;
      for (v = 0; v < 12; v++)
         add_row({c0, c1, r}, {seq[v], 5'b00000}, v == 0, 1'b0);
      c0 = base_cfg(16'h9a6c);
      c0.latch_mode = 1'b1;
      c0.clk_sel = 2'd1;
      c0.x_sel = 2'd2;
      c0.y_sel = 2'd2;
      c1 = base_cfg(16'h1e87);
      c1.comb_mode = 2'd1;
      c1.f_pin_sel = 3'b011;
      c1.g_pin_sel = 3'b100;
      c1.latch_mode = 1'b1;
      c1.clk_sel = 2'd1;
      c1.x_sel = 2'd1;
      r = 4'b0011;
      add_row({c0, c1, r}, 10'd0, 1'b1, 1'b1);
      repeat (15) add_row({c0, c1, r}, 10'd0, 1'b0, 1'b1);
      r = 4'b1001;
      add_row({c0, c1, r}, 10'd0, 1'b1, 1'b1);
      repeat (7) add_row({c0, c1, r}, 10'd0, 1'b0, 1'b1);
   endtask

   initial
   begin
      int     b;
      integer rv;
      rst_n = 1'b0;
      cfg_shift = 1'b0;
      cfg_bit = 1'b0;
      cfg_commit = 1'b0;
      pins0 = '0;
      pins1 = '0;
      model_img = '0;
      next_img = '0;
      mq[0] = 1'b0;
      mq[1] = 1'b0;
      mprev[0] = 1'b0;
      mprev[1] = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (4) @(negedge KLK);
      rst_n = 1'b1;
      foreach (rows[i])
      begin
         if (rows[i].load_cfg)
         begin
            // old configuration stays active while the image shifts in msb first.
            next_img = rows[i].img;
            for (b = TILE_CFG_BITS - 1; b >= 0; b--)
            begin
               cfg_shift = 1'b1;
               cfg_bit = rows[i].img[b];
               run_cycle(model_out());
            end
            cfg_shift = 1'b0;
            cfg_bit = 1'b0;
            cfg_commit = 1'b1;
            run_cycle(model_out());
            cfg_commit = 1'b0;
         end
         if (rows[i].rnd)
         begin
            rv = $random(seed);
            pins0 = rv[4:0];
            pins1 = rv[9:5];
         end
         else
         begin
            pins0 = rows[i].p0;
            pins1 = rows[i].p1;
         end
         rows[i].exp = model_out();
         run_cycle(rows[i].exp);
      end
      $display("%0d errors in %0d checks", errors, checks);
      if (errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

   initial
   begin
      int wd_cycles;
      wait (table_ready);
      wd_cycles = rows.size() * (TILE_CFG_BITS + 4) + 20;
      #(wd_cycles * CLK_PERIOD);
      $display("timeout: the test did not reach its end in %0d clock periods", wd_cycles);
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire
